// File: design/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// ************************************************************
// horizontal intervals, in pixel clocks
// ************************************************************
`define H_SYNC      3
`define H_BACK      3
`define H_ACTIVE    16
`define H_FRONT     2

// ************************************************************
// vertical intervals, in lines
// ************************************************************
`define V_SYNC      1
`define V_BACK      1
`define V_ACTIVE    4
`define V_FRONT     1

`define BAR_WIDTH   2   // pixels per color bar

// full line and frame lengths
`define H_TOTAL     (`H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT)
`define V_TOTAL     (`V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT)

`endif

// File: design/video_pkg.sv
package video_pkg;

    // rgb pixel, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    typedef logic [4:0]  hpos_t;    // h counter, 0 .. H_TOTAL-1
    typedef logic [2:0]  vpos_t;    // v counter, 0 .. V_TOTAL-1
    typedef logic [3:0]  col_t;     // column inside the active line

    // line fill state machine
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_LOAD,
        FILL_WAIT
    } fill_state_t;

endpackage

// File: design/pixel_stream_if.sv
`timescale 1ns/100ps

interface pixel_stream_if;
    import video_pkg::*;

    pixel_t tdata;
    logic   tvalid;
    logic   tready;
    logic   tlast;      // last pixel of a line

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// File: design/colorbar_source.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module colorbar_source (
    input  logic           sys_clk,
    input  logic           reset,
    pixel_stream_if.source m
);
    import video_pkg::*;

    col_t       col;        // column of the pixel on offer
    vpos_t      line;       // active line, 0 .. V_ACTIVE-1
    logic [2:0] bar_idx;
    logic       accept;

    assign accept = m.tvalid && m.tready;

    // ************************************************************
    // color rule
    // ************************************************************
    // bar shifts by one per line, wraps over eight colors
    assign bar_idx = 3'(col / `BAR_WIDTH + line);

    assign m.tdata = {{8{bar_idx[2]}},     // red
                      {8{bar_idx[1]}},     // green
                      {8{bar_idx[0]}}};    // blue

    assign m.tlast = (col == col_t'(`H_ACTIVE - 1));

    // ************************************************************
    // position counters, move only on an accepted pixel
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            m.tvalid <= 1'b0;
            col      <= '0;
            line     <= '0;
        end else begin
            m.tvalid <= 1'b1;                   // a pixel is always on offer
            if (accept) begin
                if (m.tlast) begin
                    col <= '0;
                    if (line == vpos_t'(`V_ACTIVE - 1)) begin
                        line <= '0;             // back to top of frame
                    end else begin
                        line <= line + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/line_fill_ctrl.sv
`timescale 1ns/100ps

module line_fill_ctrl (
    input  logic              sys_clk,
    input  logic              reset,
    pixel_stream_if.sink      s,
    input  logic              line_start,
    input  logic              line_done,
    output logic              wr_en,
    output logic              wr_bank,
    output video_pkg::col_t   wr_addr,
    output video_pkg::pixel_t wr_data,
    output logic              rd_bank,
    output logic              underrun
);
    import video_pkg::*;

    fill_state_t state;
    logic [1:0]  bank_full;     // one flag per bank
    logic        line_end;      // last pixel of a line accepted

    assign s.tready = (state == FILL_LOAD);
    assign wr_en    = s.tvalid && s.tready;
    assign wr_data  = s.tdata;
    assign line_end = wr_en && s.tlast;

    // ************************************************************
    // write side, loads lines into the free bank
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state   <= FILL_IDLE;
            wr_bank <= 1'b0;
            wr_addr <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    state <= FILL_LOAD;
                end
                FILL_LOAD: begin
                    if (line_end) begin
                        wr_addr <= '0;
                        wr_bank <= ~wr_bank;
                        // next bank not yet displayed
                        if (bank_full[~wr_bank]) begin
                            state <= FILL_WAIT;
                        end
                    end else if (wr_en) begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                FILL_WAIT: begin
                    if (!bank_full[wr_bank]) begin
                        state <= FILL_LOAD;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // ************************************************************
    // bank flags and read bank select
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            bank_full <= 2'b00;
            rd_bank   <= 1'b0;
            underrun  <= 1'b0;
        end else begin
            if (line_done) begin
                bank_full[rd_bank] <= 1'b0;     // line shown, bank is free
                rd_bank            <= ~rd_bank;
            end
            if (line_end) begin
                bank_full[wr_bank] <= 1'b1;
            end
            if (line_start && !bank_full[rd_bank]) begin
                underrun <= 1'b1;               // sticky
            end
        end
    end

endmodule

// File: design/line_buffer.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module line_buffer (
    input  logic              sys_clk,
    input  logic              wr_en,
    input  logic              wr_bank,
    input  video_pkg::col_t   wr_addr,
    input  video_pkg::pixel_t wr_data,
    input  logic              rd_en,
    input  logic              rd_bank,
    input  video_pkg::col_t   rd_addr,
    output video_pkg::pixel_t rd_data
);
    import video_pkg::*;

    // two line banks, ping-pong between fill and display
    pixel_t mem [0:1][0:`H_ACTIVE-1];

    // ************************************************************
    // write port
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // ************************************************************
    // read port, one cycle latency
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
        end
    end

endmodule

// File: design/video_timing.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module video_timing (
    input  logic              sys_clk,
    input  logic              reset,
    input  video_pkg::pixel_t rd_data,
    output logic              rd_en,
    output video_pkg::col_t   rd_addr,
    output logic              line_start,
    output logic              line_done,
    output logic              hs,
    output logic              vs,
    output logic              de,
    output video_pkg::pixel_t rgb
);
    import video_pkg::*;

    // window edges
    localparam hpos_t H_ACT_FIRST = hpos_t'(`H_SYNC + `H_BACK);
    localparam hpos_t H_ACT_LAST  = hpos_t'(`H_SYNC + `H_BACK + `H_ACTIVE - 1);
    localparam hpos_t H_LAST      = hpos_t'(`H_TOTAL - 1);
    localparam vpos_t V_ACT_FIRST = vpos_t'(`V_SYNC + `V_BACK);
    localparam vpos_t V_ACT_LAST  = vpos_t'(`V_SYNC + `V_BACK + `V_ACTIVE - 1);
    localparam vpos_t V_LAST      = vpos_t'(`V_TOTAL - 1);

    hpos_t h;
    vpos_t v;
    logic  h_act;
    logic  v_act;

    // ************************************************************
    // h and v counters, (0,0) is start of sync
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            h <= '0;
            v <= '0;
        end else if (h == H_LAST) begin
            h <= '0;
            v <= (v == V_LAST) ? '0 : v + 1'b1;     // next line
        end else begin
            h <= h + 1'b1;
        end
    end

    assign h_act = (h >= H_ACT_FIRST) && (h <= H_ACT_LAST);
    assign v_act = (v >= V_ACT_FIRST) && (v <= V_ACT_LAST);

    // read request and line pulses
    assign rd_en      = h_act && v_act;
    assign rd_addr    = col_t'(h - H_ACT_FIRST);
    assign line_start = rd_en && (h == H_ACT_FIRST);
    assign line_done  = rd_en && (h == H_ACT_LAST);

    // ************************************************************
    // outputs, one cycle late to line up with rd_data
    // ************************************************************
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
        end else begin
            hs <= (h < hpos_t'(`H_SYNC));   // active high
            vs <= (v < vpos_t'(`V_SYNC));
            de <= rd_en;
        end
    end

    assign rgb = de ? rd_data : '0;         // black outside active video

endmodule

// File: design/colorbar_video_top.sv
`timescale 1ns/100ps

module colorbar_video_top (
    input  logic        sys_clk,
    input  logic        reset,
    output logic        hs,
    output logic        vs,
    output logic        de,
    output logic [23:0] rgb,
    output logic        underrun
);
    import video_pkg::*;

    // line buffer write port
    logic   wr_en;
    logic   wr_bank;
    col_t   wr_addr;
    pixel_t wr_data;

    // line buffer read port
    logic   rd_bank;
    logic   rd_en;
    col_t   rd_addr;
    pixel_t rd_data;

    logic   line_start;
    logic   line_done;

    pixel_stream_if px_stream ();

    // ************************************************************
    // pattern source and line fill
    // ************************************************************
    colorbar_source u_colorbar_source (
        .sys_clk    (sys_clk    ),
        .reset      (reset      ),
        .m          (px_stream  )
    );

    line_fill_ctrl u_line_fill_ctrl (
        .sys_clk    (sys_clk    ),
        .reset      (reset      ),
        .s          (px_stream  ),
        .line_start (line_start ),
        .line_done  (line_done  ),
        .wr_en      (wr_en      ),
        .wr_bank    (wr_bank    ),
        .wr_addr    (wr_addr    ),
        .wr_data    (wr_data    ),
        .rd_bank    (rd_bank    ),
        .underrun   (underrun   )
    );

    // ************************************************************
    // ping-pong buffer and display timing
    // ************************************************************
    line_buffer u_line_buffer (
        .sys_clk    (sys_clk    ),
        .wr_en      (wr_en      ),
        .wr_bank    (wr_bank    ),
        .wr_addr    (wr_addr    ),
        .wr_data    (wr_data    ),
        .rd_en      (rd_en      ),
        .rd_bank    (rd_bank    ),
        .rd_addr    (rd_addr    ),
        .rd_data    (rd_data    )
    );

    video_timing u_video_timing (
        .sys_clk    (sys_clk    ),
        .reset      (reset      ),
        .rd_data    (rd_data    ),
        .rd_en      (rd_en      ),
        .rd_addr    (rd_addr    ),
        .line_start (line_start ),
        .line_done  (line_done  ),
        .hs         (hs         ),
        .vs         (vs         ),
        .de         (de         ),
        .rgb        (rgb        )
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic sys_clk,
    output logic reset
);
    localparam int HALF_PERIOD = 20;    // 40 ns clock

    initial begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD sys_clk = ~sys_clk;
    end

    // power-on reset, four rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        reset = 1'b0;
    end

endmodule

// File: dv/colorbar_video_tb.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module colorbar_video_tb;
    import video_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int H_FIRST      = `H_SYNC + `H_BACK;    // first active column
    localparam int V_FIRST      = `V_SYNC + `V_BACK;    // first active line

    logic        sys_clk;
    logic        por_reset;
    logic        mid_reset;
    logic        reset;
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] rgb;
    logic        underrun;

    // model state
    int          mh;
    int          mv;
    logic        model_ready = 1'b0;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_de;
    pixel_t      exp_rgb;

    int          seed       = 32'h81fc;
    int unsigned run_cycles = 0;

    assign reset = por_reset || mid_reset;

    tb_clock_gen u_clock_gen (
        .sys_clk (sys_clk  ),
        .reset   (por_reset)
    );

    colorbar_video_top UUT (
        .sys_clk  (sys_clk ),
        .reset    (reset   ),
        .hs       (hs      ),
        .vs       (vs      ),
        .de       (de      ),
        .rgb      (rgb     ),
        .underrun (underrun)
    );

    // ************************************************************
    // reference model
    // ************************************************************
    // bar index is col / bar width plus active line, modulo 8
    function automatic pixel_t expected_pixel(input int col, input int line);
        int bar;
        bar = (col / `BAR_WIDTH + line) % 8;
        return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
    endfunction

    function automatic logic in_active(input int h, input int v);
        return (h >= H_FIRST) && (h < H_FIRST + `H_ACTIVE) &&
               (v >= V_FIRST) && (v < V_FIRST + `V_ACTIVE);
    endfunction

    // expected outputs describe the position of the previous cycle
    always @(posedge sys_clk) begin
        model_ready <= 1'b1;
        if (reset) begin
            exp_hs  <= 1'b0;
            exp_vs  <= 1'b0;
            exp_de  <= 1'b0;
            exp_rgb <= '0;
            mh      <= 0;
            mv      <= 0;
        end else begin
            exp_hs  <= (mh < `H_SYNC);
            exp_vs  <= (mv < `V_SYNC);
            exp_de  <= in_active(mh, mv);
            exp_rgb <= in_active(mh, mv) ? expected_pixel(mh - H_FIRST, mv - V_FIRST) : '0;
            if (mh == `H_TOTAL - 1) begin
                mh <= 0;
                mv <= (mv == `V_TOTAL - 1) ? 0 : mv + 1;
            end else begin
                mh <= mh + 1;
            end
        end
    end

    // ************************************************************
    // comparison on the falling edge
    // ************************************************************
    task automatic report_mismatch(input string name, input logic [23:0] expected,
                                   input logic [23:0] actual);
        $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        $display("Errors found");
        $fatal(1, "output %s does not match the reference model", name);
    endtask

    always @(negedge sys_clk) begin
        if (model_ready) begin
            assert (hs === exp_hs) else report_mismatch("hs", 24'(exp_hs), 24'(hs));
            assert (vs === exp_vs) else report_mismatch("vs", 24'(exp_vs), 24'(vs));
            assert (de === exp_de) else report_mismatch("de", 24'(exp_de), 24'(de));
            assert (rgb === exp_rgb) else report_mismatch("rgb", exp_rgb, rgb);
            assert (underrun === 1'b0)
                else report_mismatch("underrun", 24'(0), 24'(underrun));
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    initial begin : stimulus
        int unsigned offset;
        mid_reset  = 1'b0;
        offset     = $unsigned($random(seed)) % FRAME_CYCLES;   // mid-run reset point
        run_cycles = RESET_CYCLES + 6 * FRAME_CYCLES + offset;
        wait (!por_reset);
        repeat (3 * FRAME_CYCLES) @(negedge sys_clk);
        repeat (offset) @(negedge sys_clk);
        mid_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge sys_clk);
        mid_reset = 1'b0;   // model and pattern restart at (0,0)
        repeat (3 * FRAME_CYCLES) @(negedge sys_clk);
        @(posedge sys_clk);
        $display("No errors");
        $finish;
    end

    // watchdog at twice the expected run length
    initial begin : watchdog
        wait (run_cycles != 0);
        #(2 * run_cycles * CLK_PERIOD);
        $display("Errors found");
        $fatal(1, "watchdog expired, the run did not finish in time");
    end

endmodule

// File: colorbar_video.f
+incdir+design
design/video_pkg.sv
design/pixel_stream_if.sv
design/colorbar_source.sv
design/line_fill_ctrl.sv
design/line_buffer.sv
design/video_timing.sv
design/colorbar_video_top.sv
dv/tb_clock_gen.sv
dv/colorbar_video_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status carries the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module colorbar_video_tb -f colorbar_video.f &&
./obj_dir/Vcolorbar_video_tb ||
{ echo "simulation run failed"; exit 1; }
